// ==== Bender.yml ====
package:
  name: exe_stage

sources:
  - source/exe_pkg.sv
  - source/exe_issue_if.sv
  - source/exe_forward.sv
  - source/exe_alu.sv
  - source/exe_branch.sv
  - source/exe_top.sv
  - target: test
    files:
      - tests/exe_checker.sv
      - tests/exe_monitor.sv
      - tests/tb_exe.sv

// ==== source/exe_alu.sv ====
module exe_alu (
    exe_issue_if.alu        iss,
    input  exe_pkg::xlen_t  op_a,
    input  exe_pkg::xlen_t  op_b,
    output exe_pkg::wb_t    result
);

    exe_pkg::xlen_t src2;
    exe_pkg::xlen_t value;
    logic [4:0]     shamt;

    assign src2  = iss.src2_imm ? iss.imm : op_b;
    assign shamt = src2[4:0];

    always_comb begin
        case (iss.alu_op)
            exe_pkg::ADD: begin
                value = op_a + src2;
            end
            exe_pkg::SUB: begin
                value = op_a - src2;
            end
            exe_pkg::SLT: begin
                value = {31'd0, $signed(op_a) < $signed(src2)};
            end
            exe_pkg::SLTU: begin
                value = {31'd0, op_a < src2};
            end
            exe_pkg::AND: begin
                value = op_a & src2;
            end
            exe_pkg::OR: begin
                value = op_a | src2;
            end
            exe_pkg::XOR: begin
                value = op_a ^ src2;
            end
            exe_pkg::NOR: begin
                value = ~(op_a | src2);
            end
            exe_pkg::SLL: begin
                value = op_a << shamt;
            end
            exe_pkg::SRL: begin
                value = op_a >> shamt;
            end
            exe_pkg::SRA: begin
                value = $signed(op_a) >>> shamt;
            end
            // upper immediate is already shifted by the decoder
            exe_pkg::LUI: begin
                value = src2;
            end
            default: begin
                value = '0;
            end
        endcase
    end

    assign result.en   = iss.en && (iss.kind == exe_pkg::KIND_ALU);
    assign result.rd   = iss.rd;
    assign result.data = value;

endmodule

// ==== source/exe_branch.sv ====
module exe_branch (
    exe_issue_if.br         iss,
    input  exe_pkg::xlen_t  op_a,
    input  exe_pkg::xlen_t  op_b,
    output exe_pkg::wb_t    link,
    output logic            valid,
    output logic            taken,
    output exe_pkg::xlen_t  target,
    output logic            mispredict,
    output exe_pkg::xlen_t  next_pc
);

    logic           cond;
    logic           is_link;
    exe_pkg::xlen_t seq_pc;

    always_comb begin
        case (iss.br_op)
            exe_pkg::JIRL,
            exe_pkg::B,
            exe_pkg::BL: begin
                cond = 1'b1;
            end
            exe_pkg::BEQ: begin
                cond = (op_a == op_b);
            end
            exe_pkg::BNE: begin
                cond = (op_a != op_b);
            end
            exe_pkg::BLT: begin
                cond = ($signed(op_a) < $signed(op_b));
            end
            exe_pkg::BGE: begin
                cond = ($signed(op_a) >= $signed(op_b));
            end
            exe_pkg::BLTU: begin
                cond = (op_a < op_b);
            end
            exe_pkg::BGEU: begin
                cond = (op_a >= op_b);
            end
            default: begin
                cond = 1'b0;
            end
        endcase
    end

    assign valid = iss.en && (iss.kind == exe_pkg::KIND_BR);
    assign taken = valid && cond;

    // jump-register is relative to rj, everything else to pc
    assign target = (iss.br_op == exe_pkg::JIRL) ? op_a + iss.imm : iss.pc + iss.imm;
    assign seq_pc = iss.pc + exe_pkg::LINK_OFFSET;

    assign next_pc    = taken ? target : seq_pc;
    assign mispredict = valid && (next_pc != iss.pc_next);

    assign is_link   = (iss.br_op == exe_pkg::BL) || (iss.br_op == exe_pkg::JIRL);
    assign link.en   = valid && is_link;
    assign link.rd   = iss.rd;
    assign link.data = seq_pc;

endmodule

// ==== source/exe_forward.sv ====
module exe_forward (
    exe_issue_if.fwd        iss0,
    exe_issue_if.fwd        iss1,
    input  exe_pkg::xlen_t  rf0_rj,
    input  exe_pkg::xlen_t  rf0_rk,
    input  exe_pkg::xlen_t  rf1_rj,
    input  exe_pkg::xlen_t  rf1_rk,
    input  exe_pkg::wb_t    mid0,
    input  exe_pkg::wb_t    mid1,
    input  exe_pkg::wb_t    fin0,
    input  exe_pkg::wb_t    fin1,
    output exe_pkg::xlen_t  op0_a,
    output exe_pkg::xlen_t  op0_b,
    output exe_pkg::xlen_t  op1_a,
    output exe_pkg::xlen_t  op1_b
);

    function automatic logic hit(
        input exe_pkg::reg_addr_t src,
        input exe_pkg::wb_t       slot
    );
        return slot.en && (slot.rd == src);
    endfunction

    // youngest producer first, lane 1 is younger than lane 0
    function automatic exe_pkg::xlen_t pick(
        input exe_pkg::reg_addr_t src,
        input exe_pkg::xlen_t     rf_val,
        input exe_pkg::wb_t       m1,
        input exe_pkg::wb_t       m0,
        input exe_pkg::wb_t       f1,
        input exe_pkg::wb_t       f0
    );
        exe_pkg::xlen_t val;
        if (src == '0) begin
            val = '0;
        end else if (hit(src, m1)) begin
            val = m1.data;
        end else if (hit(src, m0)) begin
            val = m0.data;
        end else if (hit(src, f1)) begin
            val = f1.data;
        end else if (hit(src, f0)) begin
            val = f0.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        op0_a = pick(iss0.rj, rf0_rj, mid1, mid0, fin1, fin0);
        op0_b = pick(iss0.rk, rf0_rk, mid1, mid0, fin1, fin0);
        op1_a = pick(iss1.rj, rf1_rj, mid1, mid0, fin1, fin0);
        op1_b = pick(iss1.rk, rf1_rk, mid1, mid0, fin1, fin0);
    end

endmodule

// ==== source/exe_issue_if.sv ====
interface exe_issue_if;

    logic                 en;
    exe_pkg::uop_kind_e   kind;
    exe_pkg::alu_op_e     alu_op;
    exe_pkg::br_op_e      br_op;
    logic                 src2_imm;
    exe_pkg::reg_addr_t   rd;
    exe_pkg::reg_addr_t   rj;
    exe_pkg::reg_addr_t   rk;
    exe_pkg::xlen_t       imm;
    exe_pkg::xlen_t       pc;
    exe_pkg::xlen_t       pc_next;

    // source register numbers for the bypass network
    modport fwd (
        input rj, rk
    );

    modport alu (
        input en, kind, alu_op, src2_imm, rd, imm
    );

    // lane 0 only
    modport br (
        input en, kind, br_op, rd, imm, pc, pc_next
    );

endinterface

// ==== source/exe_pkg.sv ====
package exe_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLT  = 4'd2,
        SLTU = 4'd3,
        AND  = 4'd4,
        OR   = 4'd5,
        XOR  = 4'd6,
        NOR  = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11
    } alu_op_e;

    // branch codes keep the decoder's numbering
    typedef enum logic [3:0] {
        BR_NONE = 4'b0000,
        JIRL    = 4'b0011,
        B       = 4'b0100,
        BL      = 4'b0101,
        BEQ     = 4'b0110,
        BNE     = 4'b0111,
        BLT     = 4'b1000,
        BGE     = 4'b1001,
        BLTU    = 4'b1010,
        BGEU    = 4'b1011
    } br_op_e;

    typedef enum logic {
        KIND_ALU = 1'b0,
        KIND_BR  = 1'b1
    } uop_kind_e;

    // one lane's slot in the middle and write-back stages
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        xlen_t     data;
    } wb_t;

    // return address distance for links
    localparam xlen_t LINK_OFFSET = 32'd4;

endpackage

// ==== source/exe_top.sv ====
module exe_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                flush_in,
    input  logic                l0_en,
    input  exe_pkg::uop_kind_e  l0_kind,
    input  exe_pkg::alu_op_e    l0_alu_op,
    input  exe_pkg::br_op_e     l0_br_op,
    input  logic                l0_src2_imm,
    input  exe_pkg::reg_addr_t  l0_rd,
    input  exe_pkg::reg_addr_t  l0_rj,
    input  exe_pkg::reg_addr_t  l0_rk,
    input  exe_pkg::xlen_t      l0_imm,
    input  exe_pkg::xlen_t      l0_pc,
    input  exe_pkg::xlen_t      l0_pc_next,
    input  exe_pkg::xlen_t      l0_rj_data,
    input  exe_pkg::xlen_t      l0_rk_data,
    input  logic                l1_en,
    input  exe_pkg::alu_op_e    l1_alu_op,
    input  logic                l1_src2_imm,
    input  exe_pkg::reg_addr_t  l1_rd,
    input  exe_pkg::reg_addr_t  l1_rj,
    input  exe_pkg::reg_addr_t  l1_rk,
    input  exe_pkg::xlen_t      l1_imm,
    input  exe_pkg::xlen_t      l1_pc,
    input  exe_pkg::xlen_t      l1_rj_data,
    input  exe_pkg::xlen_t      l1_rk_data,
    output logic                wb0_en,
    output exe_pkg::reg_addr_t  wb0_rd,
    output exe_pkg::xlen_t      wb0_data,
    output logic                wb1_en,
    output exe_pkg::reg_addr_t  wb1_rd,
    output exe_pkg::xlen_t      wb1_data,
    output logic                br_valid,
    output logic                br_taken,
    output exe_pkg::xlen_t      br_pc,
    output logic                redirect,
    output exe_pkg::xlen_t      redirect_pc
);

    exe_issue_if iss0 ();
    exe_issue_if iss1 ();

    exe_pkg::xlen_t op0_a, op0_b, op1_a, op1_b;
    exe_pkg::wb_t   alu0_res, alu1_res, br_link;
    exe_pkg::wb_t   res0;
    exe_pkg::wb_t   mid0, mid1, fin0, fin1;
    logic           br_v, br_t, br_mis;
    exe_pkg::xlen_t br_target, br_next;

    assign iss0.en       = l0_en;
    assign iss0.kind     = l0_kind;
    assign iss0.alu_op   = l0_alu_op;
    assign iss0.br_op    = l0_br_op;
    assign iss0.src2_imm = l0_src2_imm;
    assign iss0.rd       = l0_rd;
    assign iss0.rj       = l0_rj;
    assign iss0.rk       = l0_rk;
    assign iss0.imm      = l0_imm;
    assign iss0.pc       = l0_pc;
    assign iss0.pc_next  = l0_pc_next;

    // lane 1 has no branch unit
    assign iss1.en       = l1_en;
    assign iss1.kind     = exe_pkg::KIND_ALU;
    assign iss1.alu_op   = l1_alu_op;
    assign iss1.br_op    = exe_pkg::BR_NONE;
    assign iss1.src2_imm = l1_src2_imm;
    assign iss1.rd       = l1_rd;
    assign iss1.rj       = l1_rj;
    assign iss1.rk       = l1_rk;
    assign iss1.imm      = l1_imm;
    assign iss1.pc       = l1_pc;
    assign iss1.pc_next  = l1_pc + exe_pkg::LINK_OFFSET;

    exe_forward u_forward (
        .iss0   (iss0.fwd),
        .iss1   (iss1.fwd),
        .rf0_rj (l0_rj_data),
        .rf0_rk (l0_rk_data),
        .rf1_rj (l1_rj_data),
        .rf1_rk (l1_rk_data),
        .mid0   (mid0),
        .mid1   (mid1),
        .fin0   (fin0),
        .fin1   (fin1),
        .op0_a  (op0_a),
        .op0_b  (op0_b),
        .op1_a  (op1_a),
        .op1_b  (op1_b)
    );

    exe_alu u_alu0 (.iss(iss0.alu), .op_a(op0_a), .op_b(op0_b), .result(alu0_res));
    exe_alu u_alu1 (.iss(iss1.alu), .op_a(op1_a), .op_b(op1_b), .result(alu1_res));

    exe_branch u_branch (
        .iss        (iss0.br),
        .op_a       (op0_a),
        .op_b       (op0_b),
        .link       (br_link),
        .valid      (br_v),
        .taken      (br_t),
        .target     (br_target),
        .mispredict (br_mis),
        .next_pc    (br_next)
    );

    // at most one of the two is enabled
    assign res0 = br_link.en ? br_link : alu0_res;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid0        <= '0;
            mid1        <= '0;
            fin0        <= '0;
            fin1        <= '0;
            br_valid    <= 1'b0;
            br_taken    <= 1'b0;
            br_pc       <= '0;
            redirect    <= 1'b0;
            redirect_pc <= '0;
        end else if (flush_in) begin
            mid0     <= '0;
            mid1     <= '0;
            fin0     <= '0;
            fin1     <= '0;
            br_valid <= 1'b0;
            br_taken <= 1'b0;
            redirect <= 1'b0;
        end else begin
            fin0 <= mid0;
            // younger lane of a mispredicted bundle is wrong path
            fin1 <= redirect ? '0 : mid1;
            if (redirect) begin
                mid0     <= '0;
                mid1     <= '0;
                br_valid <= 1'b0;
                br_taken <= 1'b0;
                redirect <= 1'b0;
            end else begin
                mid0        <= res0;
                mid1        <= alu1_res;
                br_valid    <= br_v;
                br_taken    <= br_t;
                br_pc       <= br_target;
                redirect    <= br_mis;
                redirect_pc <= br_next;
            end
        end
    end

    assign wb0_en   = fin0.en;
    assign wb0_rd   = fin0.rd;
    assign wb0_data = fin0.data;
    assign wb1_en   = fin1.en;
    assign wb1_rd   = fin1.rd;
    assign wb1_data = fin1.data;

endmodule

// ==== tb.f ====
source/exe_pkg.sv
source/exe_issue_if.sv
source/exe_forward.sv
source/exe_alu.sv
source/exe_branch.sv
source/exe_top.sv
tests/exe_checker.sv
tests/exe_monitor.sv
tests/tb_exe.sv

// ==== tests/exe_checker.sv ====
module exe_checker (
    input logic clk,
    input logic arst_n,
    input logic wb0_en,
    input logic wb1_en,
    input logic br_valid,
    input logic redirect
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;

    // first edge out of reset
    reset_quiet: assert property (@(posedge clk)
        $rose(arst_n) |-> !(wb0_en || wb1_en || br_valid || redirect))
        else begin
            fails++;
            $error("outputs active right after reset");
        end

    redirect_has_branch: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |-> br_valid)
        else begin
            fails++;
            $error("redirect without br_valid");
        end

    // younger lane of the branch bundle is dropped
    redirect_kills_lane1: assert property (@(posedge clk) disable iff (!arst_n)
        redirect |=> !wb1_en)
        else begin
            fails++;
            $error("wb1_en high after redirect");
        end

endmodule

// ==== tests/exe_monitor.sv ====
module exe_monitor (
    input logic               clk, arst_n, flush_in,
    input logic               l0_en, l0_src2_imm, l1_en, l1_src2_imm,
    input exe_pkg::uop_kind_e l0_kind,
    input exe_pkg::alu_op_e   l0_alu_op, l1_alu_op,
    input exe_pkg::br_op_e    l0_br_op,
    input exe_pkg::reg_addr_t l0_rd, l0_rj, l0_rk, l1_rd, l1_rj, l1_rk,
    input exe_pkg::xlen_t     l0_imm, l0_pc, l0_pc_next, l1_imm,
    input logic               wb0_en, wb1_en, br_valid, br_taken, redirect,
    input exe_pkg::reg_addr_t wb0_rd, wb1_rd,
    input exe_pkg::xlen_t     wb0_data, wb1_data, br_pc, redirect_pc
);
    timeunit 1ns;
    timeprecision 1ps;

    // architectural state as seen by the next issue
    exe_pkg::xlen_t arch [32];
    exe_pkg::wb_t   mid0_e, mid1_e, fin0_e, fin1_e;
    logic           bv_e, bt_e, redir_e;
    exe_pkg::xlen_t bpc_e, rpc_e;
    int             errors = 0;
    int             checks = 0;

    function automatic exe_pkg::xlen_t alu_ref(input exe_pkg::alu_op_e op,
                                               input exe_pkg::xlen_t a, input exe_pkg::xlen_t b);
        case (op)
            exe_pkg::ADD:  return a + b;
            exe_pkg::SUB:  return a - b;
            exe_pkg::SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exe_pkg::SLTU: return (a < b) ? 32'd1 : 32'd0;
            exe_pkg::AND:  return a & b;
            exe_pkg::OR:   return a | b;
            exe_pkg::XOR:  return a ^ b;
            exe_pkg::NOR:  return ~(a | b);
            exe_pkg::SLL:  return a << b[4:0];
            exe_pkg::SRL:  return a >> b[4:0];
            exe_pkg::SRA:  return $unsigned($signed(a) >>> b[4:0]);
            default:       return b;
        endcase
    endfunction

    function automatic logic br_cond(input exe_pkg::br_op_e op,
                                     input exe_pkg::xlen_t a, input exe_pkg::xlen_t b);
        case (op)
            exe_pkg::JIRL, exe_pkg::B, exe_pkg::BL: return 1'b1;
            exe_pkg::BEQ:  return a == b;
            exe_pkg::BNE:  return a != b;
            exe_pkg::BLT:  return $signed(a) < $signed(b);
            exe_pkg::BGE:  return $signed(a) >= $signed(b);
            exe_pkg::BLTU: return a < b;
            exe_pkg::BGEU: return a >= b;
            default:       return 1'b0;
        endcase
    endfunction

    function automatic exe_pkg::xlen_t br_target(input exe_pkg::br_op_e op,
                                                 input exe_pkg::xlen_t a,
                                                 input exe_pkg::xlen_t pc,
                                                 input exe_pkg::xlen_t imm);
        return (op == exe_pkg::JIRL) ? a + imm : pc + imm;
    endfunction

    function automatic exe_pkg::xlen_t next_pc_ref(input exe_pkg::br_op_e op,
                                                   input exe_pkg::xlen_t a, input exe_pkg::xlen_t b,
                                                   input exe_pkg::xlen_t pc,
                                                   input exe_pkg::xlen_t imm);
        return br_cond(op, a, b) ? br_target(op, a, pc, imm) : pc + exe_pkg::LINK_OFFSET;
    endfunction

    function automatic logic pending();
        return mid0_e.en || mid1_e.en || fin0_e.en || fin1_e.en || bv_e;
    endfunction

    task automatic accept_bundle();
        exe_pkg::xlen_t a0, b0, a1, b1, nxt;
        a0 = arch[l0_rj];
        b0 = arch[l0_rk];
        a1 = arch[l1_rj];
        b1 = arch[l1_rk];
        mid0_e = '0;
        mid1_e = '0;
        bv_e = 1'b0;
        redir_e = 1'b0;
        if (l0_en && l0_kind == exe_pkg::KIND_BR) begin
            nxt = next_pc_ref(l0_br_op, a0, b0, l0_pc, l0_imm);
            bv_e = 1'b1;
            bt_e = br_cond(l0_br_op, a0, b0);
            bpc_e = br_target(l0_br_op, a0, l0_pc, l0_imm);
            redir_e = (nxt != l0_pc_next);
            rpc_e = nxt;
            if (l0_br_op == exe_pkg::BL || l0_br_op == exe_pkg::JIRL) begin
                mid0_e = {1'b1, l0_rd, l0_pc + exe_pkg::LINK_OFFSET};
            end
        end else if (l0_en) begin
            mid0_e = {1'b1, l0_rd, alu_ref(l0_alu_op, a0, l0_src2_imm ? l0_imm : b0)};
        end
        // wrong path when lane 0 mispredicts
        if (l1_en && !redir_e) begin
            mid1_e = {1'b1, l1_rd, alu_ref(l1_alu_op, a1, l1_src2_imm ? l1_imm : b1)};
        end
        if (mid0_e.en && mid0_e.rd != 0) arch[mid0_e.rd] = mid0_e.data;
        if (mid1_e.en && mid1_e.rd != 0) arch[mid1_e.rd] = mid1_e.data;
    endtask

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid0_e = '0;
            mid1_e = '0;
            fin0_e = '0;
            fin1_e = '0;
            bv_e = 1'b0;
            redir_e = 1'b0;
            for (int i = 0; i < 32; i++) arch[i] = '0;
        end else begin
            // write-back stage retires into the register file at this edge
            if (fin0_e.en && fin0_e.rd != 0) tb_exe.rf[fin0_e.rd] <= fin0_e.data;
            if (fin1_e.en && fin1_e.rd != 0) tb_exe.rf[fin1_e.rd] <= fin1_e.data;
            if (flush_in) begin
                // in-flight results are lost, fall back to committed state
                for (int i = 0; i < 32; i++) arch[i] = tb_exe.rf[i];
                if (fin0_e.en && fin0_e.rd != 0) arch[fin0_e.rd] = fin0_e.data;
                if (fin1_e.en && fin1_e.rd != 0) arch[fin1_e.rd] = fin1_e.data;
                mid0_e = '0;
                mid1_e = '0;
                fin0_e = '0;
                fin1_e = '0;
                bv_e = 1'b0;
                redir_e = 1'b0;
            end else begin
                fin0_e = mid0_e;
                fin1_e = mid1_e;
                if (redir_e) begin
                    mid0_e = '0;
                    mid1_e = '0;
                    bv_e = 1'b0;
                    redir_e = 1'b0;
                end else begin
                    accept_bundle();
                end
            end
        end
    end

    // outputs settled since the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            check("wb0_en", wb0_en, fin0_e.en);
            if (fin0_e.en) check("wb0_rd", wb0_rd, fin0_e.rd);
            if (fin0_e.en) check("wb0_data", wb0_data, fin0_e.data);
            check("wb1_en", wb1_en, fin1_e.en);
            if (fin1_e.en) check("wb1_rd", wb1_rd, fin1_e.rd);
            if (fin1_e.en) check("wb1_data", wb1_data, fin1_e.data);
            check("br_valid", br_valid, bv_e);
            if (bv_e) check("br_taken", br_taken, bt_e);
            if (bv_e) check("br_pc", br_pc, bpc_e);
            check("redirect", redirect, redir_e);
            if (redir_e) check("redirect_pc", redirect_pc, rpc_e);
        end
    end

endmodule

// ==== tests/tb_exe.sv ====
module tb_exe;
    timeunit 1ns;
    timeprecision 1ps;

    logic               clk, arst_n, flush_in;
    logic               l0_en, l0_src2_imm, l1_en, l1_src2_imm;
    exe_pkg::uop_kind_e l0_kind;
    exe_pkg::alu_op_e   l0_alu_op, l1_alu_op;
    exe_pkg::br_op_e    l0_br_op;
    exe_pkg::reg_addr_t l0_rd, l0_rj, l0_rk, l1_rd, l1_rj, l1_rk;
    exe_pkg::xlen_t     l0_imm, l0_pc, l0_pc_next, l1_imm, l1_pc;
    exe_pkg::xlen_t     l0_rj_data, l0_rk_data, l1_rj_data, l1_rk_data;
    logic               wb0_en, wb1_en, br_valid, br_taken, redirect;
    exe_pkg::reg_addr_t wb0_rd, wb1_rd;
    exe_pkg::xlen_t     wb0_data, wb1_data, br_pc, redirect_pc;

    // register file, written only at write-back
    exe_pkg::xlen_t rf [32];
    logic [31:0]    seed = 32'h6034_481f;

    assign l0_rj_data = rf[l0_rj];
    assign l0_rk_data = rf[l0_rk];
    assign l1_rj_data = rf[l1_rj];
    assign l1_rk_data = rf[l1_rk];

    exe_top DUT (.*);
    exe_monitor u_mon (.*);
    bind exe_top exe_checker u_checker (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic alu0(input exe_pkg::alu_op_e op, input exe_pkg::reg_addr_t rd, rj, rk,
                        input exe_pkg::xlen_t imm, input logic use_imm);
        l0_en = 1'b1;
        l0_kind = exe_pkg::KIND_ALU;
        l0_alu_op = op;
        l0_br_op = exe_pkg::BR_NONE;
        {l0_rd, l0_rj, l0_rk} = {rd, rj, rk};
        l0_imm = imm;
        l0_src2_imm = use_imm;
    endtask

    task automatic alu1(input exe_pkg::alu_op_e op, input exe_pkg::reg_addr_t rd, rj, rk,
                        input exe_pkg::xlen_t imm, input logic use_imm);
        l1_en = 1'b1;
        l1_alu_op = op;
        {l1_rd, l1_rj, l1_rk} = {rd, rj, rk};
        l1_imm = imm;
        l1_src2_imm = use_imm;
    endtask

    // predicted next pc is right or off by two words
    task automatic br0(input exe_pkg::br_op_e op, input exe_pkg::reg_addr_t rd, rj, rk,
                       input exe_pkg::xlen_t imm, pc, input logic predict_ok);
        exe_pkg::xlen_t actual;
        actual = u_mon.next_pc_ref(op, u_mon.arch[rj], u_mon.arch[rk], pc, imm);
        l0_en = 1'b1;
        l0_kind = exe_pkg::KIND_BR;
        l0_br_op = op;
        {l0_rd, l0_rj, l0_rk} = {rd, rj, rk};
        l0_imm = imm;
        l0_pc = pc;
        l0_pc_next = predict_ok ? actual : actual + 32'd8;
    endtask

    task automatic tick();
        @(negedge clk);
        l0_en = 1'b0;
        l1_en = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (u_mon.pending() || wb0_en || wb1_en || br_valid) begin
            if (n == 8) begin
                $display("timeout waiting for the pipeline to drain");
                $display("TEST FAILED");
                $finish;
            end
            tick();
            n++;
        end
    endtask

    task automatic report(input string name);
        $display("test %s finished, %0d errors so far", name,
                 u_mon.errors + DUT.u_checker.fails);
    endtask

    initial begin
        logic [31:0]     r;
        exe_pkg::br_op_e op;
        exe_pkg::br_op_e ops [10];
        int              total;
        ops = '{exe_pkg::BR_NONE, exe_pkg::JIRL, exe_pkg::B, exe_pkg::BL, exe_pkg::BEQ,
                exe_pkg::BNE, exe_pkg::BLT, exe_pkg::BGE, exe_pkg::BLTU, exe_pkg::BGEU};
        for (int i = 0; i < 32; i++) rf[i] = '0;
        {clk, arst_n, flush_in, l0_en, l1_en, l0_src2_imm, l1_src2_imm} = '0;
        l0_kind = exe_pkg::KIND_ALU;
        {l0_alu_op, l1_alu_op} = {exe_pkg::ADD, exe_pkg::ADD};
        l0_br_op = exe_pkg::BR_NONE;
        {l0_rd, l0_rj, l0_rk, l1_rd, l1_rj, l1_rk} = '0;
        {l0_imm, l0_pc, l0_pc_next, l1_imm, l1_pc} = '0;
        repeat (2) @(negedge clk);
        arst_n = 1'b1;

        tick();
        tick();
        alu0(exe_pkg::ADD, 5'd3, 5'd0, 5'd0, 32'h1234, 1'b1);
        tick();
        drain();
        report("reset");

        for (int i = 0; i < 200; i++) begin
            r = xorshift();
            alu0(exe_pkg::alu_op_e'(4'(r % 12)), r[8:4], r[13:9], r[18:14], xorshift(), r[19]);
            r = xorshift();
            alu1(exe_pkg::alu_op_e'(4'(r % 12)), r[8:4], r[13:9], r[18:14], xorshift(), r[19]);
            tick();
        end
        drain();
        report("random");

        alu0(exe_pkg::ADD, 5'd5, 5'd0, 5'd0, 32'h100, 1'b1);
        tick();
        alu0(exe_pkg::ADD, 5'd6, 5'd5, 5'd0, 32'h1, 1'b1);
        tick();
        alu0(exe_pkg::SUB, 5'd7, 5'd5, 5'd6, 32'h0, 1'b0);
        tick();
        // both lanes write r8, lane 1 is younger
        alu0(exe_pkg::ADD, 5'd8, 5'd0, 5'd0, 32'd11, 1'b1);
        alu1(exe_pkg::ADD, 5'd8, 5'd0, 5'd0, 32'd22, 1'b1);
        tick();
        alu0(exe_pkg::ADD, 5'd9, 5'd8, 5'd0, 32'h0, 1'b1);
        alu1(exe_pkg::XOR, 5'd10, 5'd8, 5'd7, 32'h0, 1'b0);
        tick();
        alu0(exe_pkg::ADD, 5'd0, 5'd0, 5'd0, 32'h7, 1'b1);
        tick();
        alu0(exe_pkg::OR, 5'd11, 5'd0, 5'd0, 32'h55, 1'b0);
        alu1(exe_pkg::ADD, 5'd12, 5'd0, 5'd5, 32'h0, 1'b0);
        tick();
        drain();
        report("chains");

        alu0(exe_pkg::ADD, 5'd12, 5'd0, 5'd0, 32'd5, 1'b1);
        alu1(exe_pkg::ADD, 5'd13, 5'd0, 5'd0, 32'hFFFF_FFFD, 1'b1);
        tick();
        alu0(exe_pkg::ADD, 5'd14, 5'd0, 5'd0, 32'd5, 1'b1);
        tick();
        drain();
        for (int k = 0; k < 10; k++) begin
            for (int p = 0; p < 3; p++) begin
                op = ops[k];
                r = xorshift();
                br0(op, (op == exe_pkg::BL) ? 5'd1 : 5'd15, (p == 2) ? 5'd13 : 5'd12,
                    (p == 0) ? 5'd14 : ((p == 1) ? 5'd13 : 5'd12), 32'h40,
                    32'h1000 + 32'(k * 64 + p * 16), 1'b1);
                alu1(exe_pkg::ADD, 5'd20 + 5'(r[2:0]), 5'd12, 5'd13, r, r[3]);
                tick();
            end
        end
        drain();
        report("branch");

        for (int k = 1; k < 5; k++) begin
            op = ops[k];
            br0(op, (op == exe_pkg::BL) ? 5'd1 : 5'd15, 5'd12, 5'd14, 32'h80, 32'h2000, 1'b0);
            alu1(exe_pkg::ADD, 5'd25, 5'd0, 5'd0, 32'h111 * k, 1'b1);
            tick();
            alu0(exe_pkg::ADD, 5'd26, 5'd0, 5'd0, 32'h77 + k, 1'b1);
            alu1(exe_pkg::ADD, 5'd27, 5'd0, 5'd0, 32'h99 + k, 1'b1);
            tick();
            drain();
            alu0(exe_pkg::OR, 5'd28, 5'd25, 5'd26, 32'h0, 1'b0);
            alu1(exe_pkg::OR, 5'd29, 5'd27, 5'd15, 32'h0, 1'b0);
            tick();
            drain();
        end
        report("mispredict");

        alu0(exe_pkg::ADD, 5'd16, 5'd0, 5'd0, 32'hA, 1'b1);
        alu1(exe_pkg::ADD, 5'd17, 5'd0, 5'd0, 32'hB, 1'b1);
        tick();
        alu0(exe_pkg::ADD, 5'd18, 5'd16, 5'd0, 32'h1, 1'b1);
        alu1(exe_pkg::ADD, 5'd19, 5'd17, 5'd0, 32'h1, 1'b1);
        tick();
        alu0(exe_pkg::ADD, 5'd16, 5'd0, 5'd0, 32'hC, 1'b1);
        flush_in = 1'b1;
        tick();
        flush_in = 1'b0;
        drain();
        alu0(exe_pkg::OR, 5'd20, 5'd16, 5'd18, 32'h0, 1'b0);
        alu1(exe_pkg::OR, 5'd21, 5'd17, 5'd19, 32'h0, 1'b0);
        tick();
        drain();
        report("flush");

        total = u_mon.errors + DUT.u_checker.fails;
        $display("checks: %0d, errors: %0d", u_mon.checks, total);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
